// ==== hdl/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ----------------------------------------------------------
// widths
// ----------------------------------------------------------
`define RV_XLEN     32          // data and address width
`define RV_NREGS    32          // integer registers x0..x31
`define RV_REG_AW   5           // register index width

// ----------------------------------------------------------
// major opcodes, instr[6:0]
// ----------------------------------------------------------
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011  // lw only
`define RV_OP_STORE   7'b0100011  // sw only
`define RV_OP_IMM     7'b0010011  // addi, slti, shifts by imm ...
`define RV_OP_REG     7'b0110011  // add, sub, ...

// ----------------------------------------------------------
// reset state
// ----------------------------------------------------------
`define RV_RESET_PC   32'h0000_0000   // first fetch address

`endif

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    // ----------------------------------------------------------
    // instruction formats, all views of the same 32-bit word
    // ----------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;     // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;  // upper immediate
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;      // sign bit
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // alu operations, encoding kept from the older core
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // one instruction walks through these in order
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY,      // lw / sw only
        ST_WRITEBACK
    } stage_e;

endpackage

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_decoder (
    input  rv_pkg::instr_u      instr,
    output logic                reg_write,
    output logic                mem_write,
    output logic                mem_to_reg,
    output logic                branch,
    output logic                jump,
    output logic                jump_reg,
    output logic                alu_in2_reg,   // 1: rs2, 0: imm
    output logic [1:0]          alu_in1_sel,   // 0: zero, 1: rs1, 2: pc
    output rv_pkg::alu_op_e     alu_op,
    output logic [`RV_XLEN-1:0] imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;        // funct7 bit 5, sub / sra select
    logic       is_reg_op;
    alu_op_e    funct_op;   // op picked by funct3 (+ funct7)

    assign opcode    = instr.r.opcode;
    assign funct3    = instr.r.funct3;
    assign alt       = instr.r.funct7[5];
    assign is_reg_op = (opcode == `RV_OP_REG);

    // ----------------------------------------------------------
    // control levels per opcode
    // ----------------------------------------------------------
    always_comb begin
        // unknown opcode falls through as a no-op
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        jump_reg    = 1'b0;
        alu_in2_reg = 1'b0;
        alu_in1_sel = 2'd1;
        alu_op      = ALU_ADD;  // address, jump, upper-imm forms
        case (opcode)
            `RV_OP_LUI: begin
                reg_write   = 1'b1;
                alu_in1_sel = 2'd0;     // 0 + imm
            end
            `RV_OP_AUIPC: begin
                reg_write   = 1'b1;
                alu_in1_sel = 2'd2;     // pc + imm
            end
            `RV_OP_JAL: begin
                reg_write = 1'b1;       // link = pc + 4
                jump      = 1'b1;
            end
            `RV_OP_JALR: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                jump_reg  = 1'b1;       // target from rs1 + imm
            end
            `RV_OP_BRANCH: begin
                branch      = 1'b1;
                alu_in2_reg = 1'b1;
                alu_op      = ALU_SUB;  // zero result means equal
            end
            `RV_OP_LOAD: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            `RV_OP_STORE: mem_write = 1'b1;
            `RV_OP_IMM: begin
                reg_write = 1'b1;
                alu_op    = funct_op;
            end
            `RV_OP_REG: begin
                reg_write   = 1'b1;
                alu_in2_reg = 1'b1;
                alu_op      = funct_op;
            end
            default: ;
        endcase
    end

    // funct3 map, shared by the imm and reg groups
    always_comb begin
        case (funct3)
            3'b000:  funct_op = (is_reg_op && alt) ? ALU_SUB : ALU_ADD;  // no subi
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b011:  funct_op = ALU_SLTU;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = alt ? ALU_SRA : ALU_SRL;  // srai keeps bit 30 too
            3'b110:  funct_op = ALU_OR;
            default: funct_op = ALU_AND;
        endcase
    end

    // ----------------------------------------------------------
    // immediate, sign extended from each format view
    // ----------------------------------------------------------
    always_comb begin
        case (opcode)
            `RV_OP_LUI, `RV_OP_AUIPC:
                imm = {instr.u.imm_31_12, 12'b0};
            `RV_OP_JAL:
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            `RV_OP_BRANCH:
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            `RV_OP_STORE:
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            default:    // I form, shifts only look at [4:0]
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        endcase
    end

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    input  logic [`RV_XLEN-1:0]   wdata,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];   // x0 is stored but never read

    // ----------------------------------------------------------
    // write port, one per write-back
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // ----------------------------------------------------------
    // read ports, combinational
    // ----------------------------------------------------------
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];   // x0 hardwired
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_execute (
    input  rv_pkg::instr_u      instr,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [1:0]          alu_in1_sel,
    input  logic                alu_in2_reg,
    input  rv_pkg::alu_op_e     alu_op,
    input  logic                branch,
    input  logic                jump,
    input  logic                jump_reg,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] next_pc
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic                br_eq;
    logic                br_lt;
    logic                br_ltu;
    logic                br_cond;
    logic                br_taken;

    // ----------------------------------------------------------
    // operands and alu
    // ----------------------------------------------------------
    always_comb begin
        case (alu_in1_sel)
            2'd0:    op_a = '0;         // lui
            2'd2:    op_a = pc;         // auipc
            default: op_a = rs1_data;
        endcase
    end

    assign op_b  = alu_in2_reg ? rs2_data : imm;
    assign shamt = op_b[4:0];           // low 5 bits only

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);  // sign fill
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;     // add, addresses, lui/auipc
        endcase
    end

    // ----------------------------------------------------------
    // branch compare and next pc
    // ----------------------------------------------------------
    assign br_eq  = (alu_result == '0);     // alu runs rs1 - rs2 on branches
    assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
    assign br_ltu = rs1_data < rs2_data;

    always_comb begin
        case (instr.b.funct3)
            3'b000:  br_cond = br_eq;       // beq
            3'b001:  br_cond = !br_eq;      // bne
            3'b100:  br_cond = br_lt;       // blt
            3'b101:  br_cond = !br_lt;      // bge
            3'b110:  br_cond = br_ltu;      // bltu
            3'b111:  br_cond = !br_ltu;     // bgeu
            default: br_cond = 1'b0;
        endcase
    end

    assign br_taken = branch && br_cond;

    assign next_pc = br_taken ? pc + imm :
                     jump_reg ? {alu_result[`RV_XLEN-1:1], 1'b0} :  // jalr drops bit 0
                     jump     ? pc + imm :                           // jal
                                pc + 32'd4;

endmodule

// ==== hdl/rv_sequencer.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_sequencer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mem_ready,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    input  logic                mem_write,
    input  logic                mem_to_reg,
    input  logic                reg_write,
    input  logic                jump,
    input  logic [`RV_XLEN-1:0] alu_result,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] next_pc,
    output rv_pkg::instr_u      instr,
    output logic [`RV_XLEN-1:0] pc,
    output logic                rf_we,
    output logic [4:0]          rf_waddr,
    output logic [`RV_XLEN-1:0] rf_wdata,
    output logic                mem_valid,
    output logic                mem_instr,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output logic [3:0]          mem_wstrb
);
    import rv_pkg::*;

    stage_e              stage_q;
    logic [`RV_XLEN-1:0] pc_q;
    instr_u              instr_q;
    logic [`RV_XLEN-1:0] load_q;    // lw data, held for write-back
    logic                store_cyc;

    // ----------------------------------------------------------
    // stage machine
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage_q <= ST_FETCH;
            pc_q    <= `RV_RESET_PC;
            instr_q <= '0;          // decodes as nothing while fetching
        end else begin
            case (stage_q)
                ST_FETCH: if (mem_ready) begin
                    instr_q <= mem_rdata;
                    stage_q <= ST_EXECUTE;
                end
                ST_EXECUTE:                         // single cycle
                    stage_q <= (mem_write || mem_to_reg) ? ST_MEMORY : ST_WRITEBACK;
                ST_MEMORY: if (mem_ready) begin
                    stage_q <= ST_WRITEBACK;
                end
                default: begin                      // write-back commits
                    pc_q    <= next_pc;
                    stage_q <= ST_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stage_q == ST_MEMORY && mem_ready) begin
            load_q <= mem_rdata;    // harmless on sw
        end
    end

    assign instr = instr_q;
    assign pc    = pc_q;

    // ----------------------------------------------------------
    // memory port, stage decoded so it holds under back-pressure
    // ----------------------------------------------------------
    assign store_cyc = (stage_q == ST_MEMORY) && mem_write;
    assign mem_valid = (stage_q == ST_FETCH) || (stage_q == ST_MEMORY);
    assign mem_instr = (stage_q == ST_FETCH);
    assign mem_addr  = (stage_q == ST_FETCH)  ? pc_q :
                       (stage_q == ST_MEMORY) ? alu_result : '0;   // rs1 + imm
    assign mem_wdata = store_cyc ? rs2_data : '0;
    assign mem_wstrb = store_cyc ? 4'b1111 : 4'b0000;   // full words only

    // write-back, load beats link beats alu
    assign rf_we    = (stage_q == ST_WRITEBACK) && reg_write;
    assign rf_waddr = instr_q.r.rd;
    assign rf_wdata = mem_to_reg ? load_q :
                      jump       ? pc_q + 32'd4 :
                                   alu_result;

    // request must not move until accepted
    a_req_hold: assert property (@(posedge clk) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_instr)
                                    && $stable(mem_wdata) && $stable(mem_wstrb))
        else $error("memory request changed before mem_ready");

    a_pc_align: assert property (@(posedge clk) disable iff (!reset_n) pc_q[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset_n,
    // native memory port
    output logic                mem_valid,
    output logic                mem_instr,
    input  logic                mem_ready,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output logic [3:0]          mem_wstrb,
    input  logic [`RV_XLEN-1:0] mem_rdata
);
    import rv_pkg::*;

    // ----------------------------------------------------------
    // stage to stage wiring
    // ----------------------------------------------------------
    instr_u                instr;
    logic [`RV_XLEN-1:0]   pc;
    logic                  reg_write, mem_write, mem_to_reg;
    logic                  branch, jump, jump_reg;
    logic                  alu_in2_reg;
    logic [1:0]            alu_in1_sel;
    alu_op_e               alu_op;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
    logic [`RV_XLEN-1:0]   alu_result, next_pc;
    logic                  rf_we;
    logic [`RV_REG_AW-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]   rf_wdata;

    rv_sequencer seq_i (
        .clk, .reset_n, .mem_ready, .mem_rdata,
        .mem_write, .mem_to_reg, .reg_write, .jump,
        .alu_result, .rs2_data, .next_pc,
        .instr, .pc, .rf_we, .rf_waddr, .rf_wdata,
        .mem_valid, .mem_instr, .mem_addr, .mem_wdata, .mem_wstrb
    );

    rv_decoder dec_i (
        .instr, .reg_write, .mem_write, .mem_to_reg,
        .branch, .jump, .jump_reg, .alu_in2_reg,
        .alu_in1_sel, .alu_op, .imm
    );

    rv_regfile rf_i (
        .clk, .reset_n,
        .we     (rf_we),
        .waddr  (rf_waddr),
        .raddr1 (instr.r.rs1),      // same slot in every format
        .raddr2 (instr.r.rs2),
        .wdata  (rf_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_execute ex_i (
        .instr, .pc, .rs1_data, .rs2_data, .imm,
        .alu_in1_sel, .alu_in2_reg, .alu_op,
        .branch, .jump, .jump_reg,
        .alu_result, .next_pc
    );

endmodule

// ==== dv/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// ----------------------------------------------------------
// instruction-set model, run once before reset is released
// ----------------------------------------------------------

// imm and reg groups, funct3 picks the operation
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sub,
                                        input logic arith, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
        3'd0:    return sub ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'h0, $signed(a) < $signed(b)};
        3'd3:    return {31'h0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return arith ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// walks ref_mem from the reset pc, fills exp_pc and the store queues
function automatic int run_reference(output logic [31:0] last_pc);
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] npc;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic        wr;
    logic        taken;
    logic        stop;
    int          n;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc   = `RV_RESET_PC;
    n    = 0;
    stop = 1'b0;
    while (!stop && n < 10000) begin
        w = ref_mem[pc[11:2]];
        exp_pc.push_back(pc);           // fetch trace
        n++;
        op    = w[6:0];
        f3    = w[14:12];
        a     = x[w[19:15]];
        b     = x[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        npc   = pc + 32'd4;
        wr    = 1'b0;
        res   = '0;
        taken = 1'b0;
        case (op)
            `RV_OP_LUI: begin
                wr  = 1'b1;
                res = {w[31:12], 12'h0};
            end
            `RV_OP_AUIPC: begin
                wr  = 1'b1;
                res = pc + {w[31:12], 12'h0};
            end
            `RV_OP_JAL: begin
                wr  = 1'b1;
                res = pc + 32'd4;       // link
                npc = pc + imm_j;
            end
            `RV_OP_JALR: begin
                wr  = 1'b1;
                res = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;     // target always even
            end
            `RV_OP_BRANCH: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    npc = pc + imm_b;
                end
            end
            `RV_OP_LOAD: begin
                addr = a + imm_i;
                wr   = 1'b1;
                res  = ref_mem[addr[11:2]];
            end
            `RV_OP_STORE: begin
                addr = a + imm_s;
                ref_mem[addr[11:2]] = b;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
            end
            `RV_OP_IMM: res = ref_alu(f3, 1'b0, w[30], a, imm_i);     // no subi
            `RV_OP_REG: res = ref_alu(f3, w[30], w[30], a, b);
            default: ;      // unsupported, plain no-op
        endcase
        if (op == `RV_OP_IMM || op == `RV_OP_REG) begin
            wr = 1'b1;
        end
        if (op == `RV_OP_JAL && imm_j == '0) begin
            stop = 1'b1;    // self-jump ends the program
        end
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = res;
        end
        pc = npc;
    end
    last_pc = pc;
    return n;
endfunction

`endif

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core_tb;

    localparam int MEM_WORDS = 1024;    // 4 KB, wraps on addr[11:2]
    localparam int WORST_CPI = 12;      // fetch 5 + exec 1 + mem 5 + wb 1

    logic                clk;
    logic                reset_n;
    logic                mem_ready = 1'b0;
    logic [`RV_XLEN-1:0] mem_rdata = '0;
    logic                mem_valid;
    logic                mem_instr;
    logic [`RV_XLEN-1:0] mem_addr;
    logic [`RV_XLEN-1:0] mem_wdata;
    logic [3:0]          mem_wstrb;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];     // reference copy
    logic [31:0] exp_pc [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] final_pc;
    integer      seed = 32'hed11;
    int          wait_cnt;
    int          errors;
    int          fetch_idx;
    int          store_idx;
    int          cycles;
    int          limit;
    int          n_instr;
    int          prog_pc;
    int          st_ofs;                 // next store slot off x10
    bit          timed_out;
    bit          first_seen;

    `include "rv_ref_model.svh"

    rv_core dut_i (
        .clk, .reset_n, .mem_valid, .mem_instr, .mem_ready,
        .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------
    // encoders, fields straight from the instruction formats
    // ----------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input int imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input int imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input int imm);
        return {imm[19:0], rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_pc[11:2]] = word;
        prog_pc += 4;
    endtask

    task automatic emit_store(input logic [4:0] rs);
        emit(enc_s(rs, 5'd10, st_ofs));
        st_ofs += 4;
    endtask

    // bump x11, branch over the store of x11 when taken
    task automatic emit_branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2);
        emit(enc_i(`RV_OP_IMM, 5'd11, 3'd0, 5'd11, 1));
        emit(enc_b(f3, rs1, rs2, 8));
        emit_store(5'd11);
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hdead_0000 | i;
        end
        mem['h600 >> 2] = 32'hcafe_f00d;                    // preloaded word
        prog_pc = 0;
        st_ofs  = 0;
        emit(enc_i(`RV_OP_IMM, 5'd10, 3'd0, 5'd0, 'h400));  // store base
        emit(enc_i(`RV_OP_IMM, 5'd1, 3'd0, 5'd0, -100));    // x1 negative
        emit(enc_i(`RV_OP_IMM, 5'd2, 3'd0, 5'd0, 7));
        for (int f = 0; f < 8; f++) begin                   // imm group
            emit(enc_i(`RV_OP_IMM, 5'd3, f[2:0], 5'd1, (f == 1 || f == 5) ? 3 : -37));
            emit_store(5'd3);
        end
        emit(enc_i(`RV_OP_IMM, 5'd3, 3'd5, 5'd1, 'h402));   // srai on negative
        emit_store(5'd3);
        for (int f = 0; f < 8; f++) begin                   // reg group
            emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd3));
            emit_store(5'd3);
        end
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));         // sub
        emit_store(5'd3);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));         // sra
        emit_store(5'd3);
        emit(enc_u(`RV_OP_LUI, 5'd4, 'habcde));
        emit_store(5'd4);
        emit(enc_u(`RV_OP_AUIPC, 5'd4, 'h12));
        emit_store(5'd4);
        emit(enc_j(5'd5, 8));                               // jal over one instr
        emit(enc_i(`RV_OP_IMM, 5'd6, 3'd0, 5'd0, 1));
        emit_store(5'd5);
        emit_store(5'd6);
        emit(enc_u(`RV_OP_AUIPC, 5'd7, 0));
        emit(enc_i(`RV_OP_JALR, 5'd8, 3'd0, 5'd7, 13));     // odd target
        emit(enc_i(`RV_OP_IMM, 5'd6, 3'd0, 5'd0, 2));
        emit_store(5'd8);
        emit_store(5'd6);
        emit_branch_case(3'd0, 5'd2, 5'd2);                 // beq taken
        emit_branch_case(3'd0, 5'd1, 5'd2);
        emit_branch_case(3'd1, 5'd1, 5'd2);                 // bne taken
        emit_branch_case(3'd1, 5'd2, 5'd2);
        emit_branch_case(3'd4, 5'd1, 5'd2);                 // blt taken
        emit_branch_case(3'd4, 5'd2, 5'd1);
        emit_branch_case(3'd5, 5'd2, 5'd1);                 // bge taken
        emit_branch_case(3'd5, 5'd1, 5'd2);
        emit_branch_case(3'd6, 5'd2, 5'd1);                 // bltu taken
        emit_branch_case(3'd6, 5'd1, 5'd2);
        emit_branch_case(3'd7, 5'd1, 5'd2);                 // bgeu taken
        emit_branch_case(3'd7, 5'd2, 5'd1);
        emit(enc_i(`RV_OP_IMM, 5'd12, 3'd0, 5'd12, 1));     // backward loop, 7 turns
        emit(enc_b(3'd1, 5'd12, 5'd2, -4));
        emit_store(5'd12);
        emit(enc_i(`RV_OP_LOAD, 5'd13, 3'd2, 5'd10, 0));    // first stored word
        emit_store(5'd13);
        emit(enc_i(`RV_OP_LOAD, 5'd14, 3'd2, 5'd0, 'h600));
        emit_store(5'd14);
        emit(enc_i(`RV_OP_IMM, 5'd0, 3'd0, 5'd0, 5));       // x0 stays zero
        emit(enc_i(`RV_OP_LOAD, 5'd0, 3'd2, 5'd10, 4));
        emit_store(5'd0);
        emit(32'h0000_018f);                                // unsupported, rd x3
        emit_store(5'd3);
        emit(enc_j(5'd0, 0));                               // self-jump
    endtask

    // ----------------------------------------------------------
    // memory model, ready after 0..3 extra cycles
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (!reset_n) begin
            mem_ready <= 1'b0;
            wait_cnt  <= $random(seed) & 3;
        end else if (mem_ready) begin           // transfer on this edge
            if (mem_wstrb != 4'h0) begin
                mem[mem_addr[11:2]] = mem_wdata;
            end
            mem_ready <= 1'b0;
            wait_cnt  <= $random(seed) & 3;     // next request's delay
        end else if (mem_valid) begin
            if (wait_cnt == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr[11:2]];
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %08h expected %08h", name, got, expected);
            errors++;
        end
    endtask

    // ----------------------------------------------------------
    // compare accepted transfers with the reference
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (reset_n && mem_valid && !first_seen) begin     // first request after reset
            first_seen = 1'b1;
            check_value("mem_instr", {31'h0, mem_instr}, 32'h1);
            check_value("mem_addr", mem_addr, `RV_RESET_PC);
            check_value("mem_wstrb", {28'h0, mem_wstrb}, 32'h0);
        end
        if (reset_n && mem_valid && mem_ready) begin
            if (mem_instr) begin
                check_value("mem_wstrb", {28'h0, mem_wstrb}, 32'h0);
                if (fetch_idx < exp_pc.size()) begin
                    check_value("mem_addr", mem_addr, exp_pc[fetch_idx]);
                end else begin
                    check_value("mem_addr", mem_addr, final_pc);   // parked on self-jump
                end
                fetch_idx++;
            end else if (mem_wstrb != 4'h0) begin
                check_value("mem_wstrb", {28'h0, mem_wstrb}, 32'hf);
                if (store_idx < exp_st_addr.size()) begin
                    check_value("mem_addr", mem_addr, exp_st_addr[store_idx]);
                    check_value("mem_wdata", mem_wdata, exp_st_data[store_idx]);
                end else begin
                    $display("store to %08h came after the last expected store", mem_addr);
                    errors++;
                end
                store_idx++;
            end
        end
    end

    always @(posedge clk) begin
        if (reset_n) begin
            cycles++;
            if (cycles >= limit) begin
                timed_out = 1'b1;
            end
        end
    end

    initial begin
        reset_n <= 1'b0;
        load_program();
        ref_mem = mem;
        n_instr = run_reference(final_pc);
        limit   = 8 * n_instr * WORST_CPI;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        // one fetch past the trace, the self-jump must land on itself
        while (!timed_out && (fetch_idx <= exp_pc.size() || store_idx < exp_st_addr.size())) begin
            @(negedge clk);
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, the program never reached its last fetch",
                     cycles);
        end
        $display("errors %0d, timeout %0d, stores %0d of %0d, fetches %0d of %0d",
                 errors, timed_out, store_idx, exp_st_addr.size(), fetch_idx,
                 exp_pc.size() + 1);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
+incdir+dv
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_sequencer.sv
hdl/rv_core.sv
dv/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build rv_core_tb with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert \
    -f files.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
